// ==== uart_cfg_pkg.sv ====
// timing, baud divisor, word width, fifo and credit constants for the low-power uart rx
`default_nettype none

package uart_cfg_pkg;

    // idle detection
    localparam int unsigned idle_w = 16;
    localparam logic [idle_w-1:0] idle_timeout = 16'd200; // quiet cycles before idle_irq

    // bit timing
    localparam int unsigned baud_div   = 4;  // gated_clk cycles per oversample tick
    localparam int unsigned oversample = 16; // ticks per bit
    localparam int unsigned data_bits  = 8;

    // flow control
    localparam int unsigned rx_credits = 4;  // consumer slots
    localparam int unsigned fifo_depth = 8;

    // derived widths
    localparam int unsigned div_w      = $clog2(baud_div);
    localparam int unsigned tick_w     = $clog2(oversample);
    localparam int unsigned bit_cnt_w  = $clog2(data_bits);
    localparam int unsigned ptr_w      = $clog2(fifo_depth);
    localparam int unsigned fifo_cnt_w = $clog2(fifo_depth + 1);
    localparam int unsigned credit_w   = $clog2(rx_credits + 1);

    // derived compare values, sized to their counters
    localparam logic [div_w-1:0]      div_last    = div_w'(baud_div - 1);
    localparam logic [tick_w-1:0]     tick_mid    = tick_w'(oversample / 2 - 1); // tick 8 of 16
    localparam logic [tick_w-1:0]     tick_last   = tick_w'(oversample - 1);
    localparam logic [bit_cnt_w-1:0]  bit_last    = bit_cnt_w'(data_bits - 1);
    localparam logic [fifo_cnt_w-1:0] fifo_full   = fifo_cnt_w'(fifo_depth);
    localparam logic [ptr_w-1:0]      ptr_last    = ptr_w'(fifo_depth - 1);
    localparam logic [credit_w-1:0]   credit_init = credit_w'(rx_credits);

endpackage

`default_nettype wire

// ==== uart_types_pkg.sv ====
// received word and low-power status structs
`default_nettype none

package uart_types_pkg;

    // one received frame
    typedef struct packed {
        logic                               framing_err; // stop bit was low
        logic [uart_cfg_pkg::data_bits-1:0] data;
    } rx_word_t;

    // interrupt and power state seen by software
    typedef struct packed {
        logic wake_irq;   // line activity while sleep requested
        logic idle_irq;   // line quiet for idle_timeout cycles
        logic core_awake; // receive core clock running
    } lp_status_t;

endpackage

`default_nettype wire

// ==== line_wake_monitor.sv ====
// line_wake_monitor: rxd synchronizer, edge flag, idle countdown, wake/idle irqs, clock enable
`timescale 1ns/1ps
`default_nettype none

module line_wake_monitor (
    input  wire  gated_clk,
    input  wire  rst_n,
    input  wire  rxd,
    input  wire  sleep_en,
    input  wire  gate_en,
    output logic clk_en,
    output logic rxd_sync,
    output logic wake_irq,
    output logic idle_irq
);

    logic                            rxd_meta;  // first synchronizer stage
    logic                            rxd_prev;
    logic                            edge_seen;
    logic                            activity;
    logic [uart_cfg_pkg::idle_w-1:0] idle_cnt;

    // two-flop synchronizer, line idles high
    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // any transition counts as activity
    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            edge_seen <= 1'b0;
        end else begin
            edge_seen <= rxd_sync ^ rxd_prev;
        end
    end

    // idle countdown, reloaded on every edge so one idle_irq per burst
    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            idle_cnt <= '0;
            activity <= 1'b0;
            idle_irq <= 1'b0;
            wake_irq <= 1'b0;
        end else begin
            idle_irq <= 1'b0;
            wake_irq <= edge_seen && !activity && sleep_en; // only on the rising activity
            if (edge_seen) begin
                idle_cnt <= uart_cfg_pkg::idle_timeout;
                activity <= 1'b1;
            end else if (idle_cnt != '0) begin
                idle_cnt <= idle_cnt - 1'b1;
                if (idle_cnt == uart_cfg_pkg::idle_w'(1)) begin
                    activity <= 1'b0; // quiet long enough, core may sleep
                    idle_irq <= 1'b1;
                end
            end
        end
    end

    // without gate_en the core clock is never stopped
    assign clk_en = activity || !sleep_en || !gate_en;

endmodule

`default_nettype wire

// ==== core_clock_gate.sv ====
// core_clock_gate: falling-edge enable register and and-gate producing core_clk
`timescale 1ns/1ps
`default_nettype none

module core_clock_gate (
    input  wire  gated_clk,
    input  wire  rst_n,
    input  wire  clk_en,
    output logic core_clk,
    output logic core_awake
);

    logic en_q;

    // captured while gated_clk is low, so the and below cannot glitch
    always_ff @(negedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q <= 1'b1; // core runs out of reset
        end else begin
            en_q <= clk_en;
        end
    end

    assign core_clk   = gated_clk & en_q;
    assign core_awake = en_q;

endmodule

`default_nettype wire

// ==== uart_rx_core.sv ====
// uart_rx_core: oversampled 8n1 receive fsm with tick divider, bit counter and shift register
`timescale 1ns/1ps
`default_nettype none

module uart_rx_core (
    input  wire                      core_clk,
    input  wire                      rst_n,
    input  wire                      rxd_sync,
    output logic                     word_strobe,
    output uart_types_pkg::rx_word_t word
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t                                state_q;
    logic [uart_cfg_pkg::div_w-1:0]        div_cnt;
    logic [uart_cfg_pkg::tick_w-1:0]       tick_cnt;
    logic [uart_cfg_pkg::bit_cnt_w-1:0]    bit_cnt;
    logic [uart_cfg_pkg::data_bits-1:0]    shift_q;
    logic                                  rxd_prev;
    logic                                  start_edge;
    logic                                  tick;
    logic                                  sample_pt;
    logic                                  bit_end;

    // prev holds its value across sleep, so a wake still sees the falling edge
    assign start_edge = rxd_prev && !rxd_sync;
    assign tick       = (div_cnt == uart_cfg_pkg::div_last);
    assign sample_pt  = tick && (tick_cnt == uart_cfg_pkg::tick_mid);  // mid-bit
    assign bit_end    = tick && (tick_cnt == uart_cfg_pkg::tick_last);

    // oversample counters, restarted at each start edge
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt  <= '0;
            tick_cnt <= '0;
        end else if (state_q == st_idle) begin
            div_cnt  <= '0;
            tick_cnt <= '0;
        end else if (tick) begin
            div_cnt  <= '0;
            tick_cnt <= (tick_cnt == uart_cfg_pkg::tick_last) ? '0 : tick_cnt + 1'b1;
        end else begin
            div_cnt  <= div_cnt + 1'b1;
        end
    end

    // frame fsm
    always_ff @(posedge core_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= st_idle;
            bit_cnt     <= '0;
            rxd_prev    <= 1'b1;
            word_strobe <= 1'b0;
        end else begin
            rxd_prev    <= rxd_sync;
            word_strobe <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (start_edge) state_q <= st_start;
                end
                st_start: begin
                    if (sample_pt && rxd_sync) begin
                        state_q <= st_idle; // glitch, not a start bit
                    end else if (bit_end) begin
                        state_q <= st_data;
                        bit_cnt <= '0;
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        if (bit_cnt == uart_cfg_pkg::bit_last) state_q <= st_stop;
                        else bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_stop: begin
                    if (sample_pt) begin
                        state_q     <= st_idle; // rearm during second half of stop
                        word_strobe <= 1'b1;
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // lsb first
    always_ff @(posedge core_clk) begin
        if (state_q == st_data && sample_pt) begin
            shift_q <= {rxd_sync, shift_q[uart_cfg_pkg::data_bits-1:1]};
        end
        if (state_q == st_stop && sample_pt) begin
            word.data        <= shift_q;
            word.framing_err <= !rxd_sync;
        end
    end

endmodule

`default_nettype wire

// ==== rx_credit_fifo.sv ====
// rx_credit_fifo: circular word buffer with bypass and credit counter toward the consumer
`timescale 1ns/1ps
`default_nettype none

module rx_credit_fifo (
    input  wire                      gated_clk,
    input  wire                      rst_n,
    input  wire                      word_strobe,
    input  uart_types_pkg::rx_word_t word,
    input  wire                      credit_ret,
    output logic                     rx_valid,
    output uart_types_pkg::rx_word_t rx_word
);

    uart_types_pkg::rx_word_t             mem [uart_cfg_pkg::fifo_depth];
    logic [uart_cfg_pkg::ptr_w-1:0]       wr_ptr;
    logic [uart_cfg_pkg::ptr_w-1:0]       rd_ptr;
    logic [uart_cfg_pkg::fifo_cnt_w-1:0]  count;
    logic [uart_cfg_pkg::credit_w-1:0]    credit;
    logic                                 empty;
    logic                                 send;
    logic                                 push;
    logic                                 pop;

    assign empty = (count == '0);
    assign send  = (credit != '0) && (!empty || word_strobe);
    assign pop   = send && !empty;
    // a word that goes straight out skips the buffer, full drops the word
    assign push  = word_strobe && !(send && empty) && (count != uart_cfg_pkg::fifo_full);

    always_ff @(posedge gated_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit   <= uart_cfg_pkg::credit_init;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= send;
            if (push) wr_ptr <= (wr_ptr == uart_cfg_pkg::ptr_last) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == uart_cfg_pkg::ptr_last) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({credit_ret, send}) // send and return together cancel
                2'b10:   credit <= credit + 1'b1;
                2'b01:   credit <= credit - 1'b1;
                default: credit <= credit;
            endcase
        end
    end

    always_ff @(posedge gated_clk) begin
        if (push) mem[wr_ptr] <= word;
        if (send) rx_word <= empty ? word : mem[rd_ptr];
    end

endmodule

`default_nettype wire

// ==== uart_lp_rx_top.sv ====
// uart_lp_rx_top: wake monitor, core clock gate, rx core and credit fifo
`timescale 1ns/1ps
`default_nettype none

module uart_lp_rx_top (
    input  wire                        gated_clk,
    input  wire                        rst_n,
    input  wire                        rxd,
    input  wire                        sleep_en,
    input  wire                        gate_en,
    input  wire                        credit_ret,
    output logic                       rx_valid,
    output uart_types_pkg::rx_word_t   rx_word,
    output uart_types_pkg::lp_status_t status
);

    logic                     clk_en;
    logic                     rxd_sync;
    logic                     wake_irq;
    logic                     idle_irq;
    logic                     core_clk;
    logic                     core_awake;
    logic                     word_strobe;
    uart_types_pkg::rx_word_t word;

    line_wake_monitor monitor_i (
        .gated_clk (gated_clk),
        .rst_n     (rst_n),
        .rxd       (rxd),
        .sleep_en  (sleep_en),
        .gate_en   (gate_en),
        .clk_en    (clk_en),
        .rxd_sync  (rxd_sync),
        .wake_irq  (wake_irq),
        .idle_irq  (idle_irq)
    );

    core_clock_gate gate_i (
        .gated_clk  (gated_clk),
        .rst_n      (rst_n),
        .clk_en     (clk_en),
        .core_clk   (core_clk),
        .core_awake (core_awake)
    );

    uart_rx_core core_i (
        .core_clk    (core_clk),
        .rst_n       (rst_n),
        .rxd_sync    (rxd_sync),
        .word_strobe (word_strobe),
        .word        (word)
    );

    // strobe comes from core_clk but is one gated_clk cycle wide
    rx_credit_fifo fifo_i (
        .gated_clk   (gated_clk),
        .rst_n       (rst_n),
        .word_strobe (word_strobe),
        .word        (word),
        .credit_ret  (credit_ret),
        .rx_valid    (rx_valid),
        .rx_word     (rx_word)
    );

    assign status = '{wake_irq: wake_irq, idle_irq: idle_irq, core_awake: core_awake};

endmodule

`default_nettype wire

// ==== rx_checker.sv ====
// rx_checker: expected word queue, credit, idle, wake and sleep models compared with DUT ports
`timescale 1ns/1ps
`default_nettype none

module rx_checker (
    input wire                        gated_clk,
    input wire                        rst_n,
    input wire                        rxd,
    input wire                        sleep_en,
    input wire                        gate_en,
    input wire                        credit_ret,
    input wire                        rx_valid,
    input uart_types_pkg::rx_word_t   rx_word,
    input uart_types_pkg::lp_status_t status
);

    localparam int tmo      = uart_cfg_pkg::idle_timeout;
    localparam int edge_lag = 4; // rxd change to countdown reload in the monitor

    uart_types_pkg::rx_word_t exp_q[$];
    uart_types_pkg::rx_word_t w;
    int   errors      = 0;
    int   words_seen  = 0;
    int   outstanding = 0;
    int   since_edge  = 0;
    int   wake_exp    = 0;
    int   wake_seen   = 0;
    int   sleep_cnt   = 0;
    int   run_cnt     = 0;
    int   wake_wait   = 0;
    logic rxd_last    = 1'b1;
    logic line_edge   = 1'b0;
    logic [edge_lag-1:0] edge_pipe = '0;
    logic quiet       = 1'b1; // monitor activity is low out of reset
    logic armed       = 1'b0;

    task automatic expect_word(input uart_types_pkg::rx_word_t ew);
        exp_q.push_back(ew);
    endtask

    task automatic compare(input string name, input int expv, input int actv);
        if (expv != actv) begin
            errors++;
            $display("FAIL %s expected %0h actual %0h at %0t", name, expv, actv, $time);
        end
    endtask

    task automatic problem(input string what);
        errors++;
        $display("ERROR %s at %0t", what, $time);
    endtask

    task automatic final_check();
        if (exp_q.size() != 0) problem("frames were sent but their words never arrived");
        compare("wake_count", wake_exp, wake_seen);
    endtask

    // negedge sampling, outputs and tb drives are settled here
    always @(negedge gated_clk) begin
        if (rst_n) begin
            if (wake_wait > 0) begin
                if (status.core_awake) wake_wait = 0;
                else if (wake_wait == 7) begin
                    problem("core clock did not restart within 6 cycles of line activity");
                    wake_wait = 0;
                end else wake_wait++;
            end
            line_edge = (rxd !== rxd_last);
            rxd_last  = rxd;
            if (line_edge && !status.core_awake) wake_wait = 1;
            // idle and wake follow the edge as the monitor sees it
            if (edge_pipe[edge_lag-1]) begin
                if (quiet && sleep_en) wake_exp++; // activity rises while sleep requested
                quiet      = 1'b0;
                armed      = 1'b1;
                since_edge = 0;
            end else since_edge++;
            edge_pipe = {edge_pipe[edge_lag-2:0], line_edge};
            if (status.idle_irq) begin
                if (!armed) problem("idle_irq without a line change before it");
                else if (since_edge + edge_lag < tmo || since_edge + edge_lag > tmo + 5)
                    compare("idle_irq_delay", tmo, since_edge + edge_lag);
                armed = 1'b0;
                quiet = 1'b1;
            end else if (armed && since_edge + edge_lag > tmo + 5) begin
                problem("idle_irq missing after a quiet line");
                armed = 1'b0;
                quiet = 1'b1;
            end
            if (status.wake_irq) wake_seen++;
            sleep_cnt = (quiet && sleep_en && gate_en) ? sleep_cnt + 1 : 0;
            run_cnt   = (!sleep_en || !gate_en) ? run_cnt + 1 : 0;
            if (sleep_cnt >= 2) compare("core_awake_sleep", 0, status.core_awake);
            if (run_cnt >= 2) compare("core_awake_forced", 1, status.core_awake);
            if (rx_valid) begin
                words_seen++;
                outstanding++;
                if (exp_q.size() == 0) problem("rx_valid with no frame outstanding");
                else begin
                    w = exp_q.pop_front();
                    compare("rx_data", w.data, rx_word.data);
                    compare("framing_err", w.framing_err, rx_word.framing_err);
                end
            end
            if (credit_ret) outstanding--;
            if (outstanding > uart_cfg_pkg::rx_credits)
                problem("more words presented than the consumer has credits for");
        end
    end

endmodule

`default_nettype wire

// ==== tb_uart_lp_rx.sv ====
// tb_uart_lp_rx: clock, reset, random serial frames, random credit return, watchdog, final report
`timescale 1ns/1ps
`default_nettype none

module tb_uart_lp_rx;

    localparam int bit_cycles    = uart_cfg_pkg::baud_div * uart_cfg_pkg::oversample;
    localparam int num_bursts    = 12;
    localparam int max_frames    = 5;
    localparam int max_short_gap = 180;
    localparam int max_long_gap  = 600;
    // every frame with its widest gap, every burst gap, plus drain time
    localparam int run_limit = num_bursts * max_frames * (10 * bit_cycles + max_short_gap)
                             + num_bursts * max_long_gap + 4000;

    logic                       gated_clk;
    logic                       rst_n;
    logic                       rxd;
    logic                       sleep_en;
    logic                       gate_en;
    logic                       credit_ret;
    logic                       rx_valid;
    uart_types_pkg::rx_word_t   rx_word;
    uart_types_pkg::lp_status_t status;
    logic                       hold_credits; // consumer keeps every slot busy
    int                         pend[$];   // consumer slots still in use, cycles left
    int unsigned                seed_val;

    uart_lp_rx_top dut_i (
        .gated_clk  (gated_clk),
        .rst_n      (rst_n),
        .rxd        (rxd),
        .sleep_en   (sleep_en),
        .gate_en    (gate_en),
        .credit_ret (credit_ret),
        .rx_valid   (rx_valid),
        .rx_word    (rx_word),
        .status     (status)
    );

    rx_checker chk_i (
        .gated_clk  (gated_clk),
        .rst_n      (rst_n),
        .rxd        (rxd),
        .sleep_en   (sleep_en),
        .gate_en    (gate_en),
        .credit_ret (credit_ret),
        .rx_valid   (rx_valid),
        .rx_word    (rx_word),
        .status     (status)
    );

    initial begin
        gated_clk = 1'b0;
        forever #50 gated_clk = ~gated_clk;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge gated_clk);
        #1;
    endtask

    // no run of 4 equal bits before mid-stop, so the core never sleeps inside a frame
    function automatic logic [7:0] limit_runs(input logic [7:0] d, input logic stop_bit);
        logic [9:0] s;
        s = {stop_bit, d, 1'b0};
        for (int i = 3; i <= 8; i++) begin
            if (s[i] == s[i-1] && s[i-1] == s[i-2] && s[i-2] == s[i-3]) s[i] = ~s[i];
        end
        if (s[9] == s[8] && s[8] == s[7] && s[7] == s[6]) s[8] = ~s[8];
        return s[8:1];
    endfunction

    task automatic send_frame(input logic [7:0] d, input logic stop_bit);
        rxd = 1'b0; // start bit
        wait_cycles(bit_cycles);
        for (int i = 0; i < uart_cfg_pkg::data_bits; i++) begin
            rxd = d[i]; // lsb first
            wait_cycles(bit_cycles);
        end
        rxd = stop_bit;
        wait_cycles(bit_cycles);
        rxd = 1'b1;
    endtask

    // consumer frees each slot after a random delay, none while stalled
    initial begin
        logic stalled;
        forever begin
            @(posedge gated_clk);
            stalled = hold_credits;
            #1;
            credit_ret = 1'b0;
            if (rx_valid) pend.push_back($urandom_range(1, 40));
            foreach (pend[i]) if (pend[i] > 0) pend[i]--;
            if (!stalled && pend.size() > 0 && pend[0] == 0) begin
                credit_ret = 1'b1;
                void'(pend.pop_front());
            end
        end
    end

    initial begin
        repeat (run_limit) @(posedge gated_clk);
        $display("watchdog expired after %0d cycles, the DUT stopped producing words", run_limit);
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [7:0] d;
        logic       stop_bit;
        int         n;
        int         gap;
        seed_val     = $urandom(94113);
        rst_n        = 1'b0;
        rxd          = 1'b1;
        sleep_en     = 1'b1;
        gate_en      = 1'b1;
        credit_ret   = 1'b0;
        hold_credits = 1'b0;
        wait_cycles(10);
        rst_n = 1'b1;
        wait_cycles(20);
        for (int b = 0; b < num_bursts; b++) begin
            hold_credits = (b % 4 == 2); // more frames than credits, fifo keeps the rest
            n = hold_credits ? max_frames : $urandom_range(1, max_frames);
            for (int f = 0; f < n; f++) begin
                stop_bit = ($urandom_range(0, 7) != 0); // about one in eight bad
                d        = limit_runs(8'($urandom), stop_bit);
                chk_i.expect_word('{framing_err: !stop_bit, data: d});
                send_frame(d, stop_bit);
                wait_cycles($urandom_range(40, max_short_gap));
            end
            hold_credits = 1'b0;
            if ($urandom_range(0, 2) != 0) gap = $urandom_range(uart_cfg_pkg::idle_timeout + 20,
                                                               max_long_gap);
            else gap = $urandom_range(40, max_short_gap);
            wait_cycles(20);
            sleep_en = 1'($urandom_range(0, 1));
            gate_en  = 1'($urandom_range(0, 1));
            wait_cycles(gap);
        end
        while (chk_i.exp_q.size() != 0) @(posedge gated_clk);
        wait_cycles(uart_cfg_pkg::idle_timeout + 20); // let the last idle_irq arrive
        chk_i.final_check();
        $display("words checked %0d, errors %0d", chk_i.words_seen, chk_i.errors);
        if (chk_i.errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
uart_cfg_pkg.sv
uart_types_pkg.sv
line_wake_monitor.sv
core_clock_gate.sv
uart_rx_core.sv
rx_credit_fifo.sv
uart_lp_rx_top.sv
rx_checker.sv
tb_uart_lp_rx.sv
